// ==== logic/iadc_defs.svh ====
`ifndef IADC_DEFS_SVH
`define IADC_DEFS_SVH

//////////////////////////////////////////////////
// serial control frame layout
//////////////////////////////////////////////////

`define IADC_ADDR_W  3   // register address bits.
`define IADC_CDATA_W 16  // register data bits.
`define IADC_FRAME_W (`IADC_ADDR_W + `IADC_CDATA_W)

//////////////////////////////////////////////////
// control port timing, in adc_clk cycles
//////////////////////////////////////////////////

// one control bit period, even so the clock splits into two halves.
`define IADC_CTRL_DIV 4

`define IADC_DDRB_CYCLES 8  // length of the ddrb reset pulse.

`endif

// ==== logic/iadc_pkg.sv ====
`include "iadc_defs.svh"

package iadc_pkg;

  //////////////////////////////////////////////////
  // capture path
  //////////////////////////////////////////////////

  typedef logic [7:0]  lane_t;         // one 8-bit bus from the adc.
  typedef logic [63:0] sample_word_t;  // four lanes, both edges.
  typedef logic [3:0]  oor_t;          // i and q flags, both edges.

  //////////////////////////////////////////////////
  // control path
  //////////////////////////////////////////////////

  typedef logic [`IADC_ADDR_W-1:0]  ctrl_addr_t;
  typedef logic [`IADC_CDATA_W-1:0] ctrl_data_t;
  typedef logic [`IADC_FRAME_W-1:0] ctrl_frame_t;

  // write sequence and reset pulse share the idle state.
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_SHIFT,
    ST_HOLD,
    ST_DDRB
  } ctrl_state_t;

endpackage

// ==== logic/iadc_ddr_capture.sv ====
`timescale 1ns/1ps

module iadc_ddr_capture (
  input  logic                  adc_clk,
  input  logic                  rst_n,
  input  iadc_pkg::lane_t       data_i_even,
  input  iadc_pkg::lane_t       data_i_odd,
  input  iadc_pkg::lane_t       data_q_even,
  input  iadc_pkg::lane_t       data_q_odd,
  input  logic                  oor_i,
  input  logic                  oor_q,
  input  logic                  sync_in,
  output iadc_pkg::sample_word_t adc_data,
  output iadc_pkg::oor_t        adc_oor,
  output logic                  adc_sync
);

  // rising edge samples.
  iadc_pkg::lane_t i_even_r;
  iadc_pkg::lane_t i_odd_r;
  iadc_pkg::lane_t q_even_r;
  iadc_pkg::lane_t q_odd_r;
  logic            oor_i_r;
  logic            oor_q_r;

  // falling edge samples.
  iadc_pkg::lane_t i_even_f;
  iadc_pkg::lane_t i_odd_f;
  iadc_pkg::lane_t q_even_f;
  iadc_pkg::lane_t q_odd_f;
  logic            oor_i_f;
  logic            oor_q_f;

  always_ff @(posedge adc_clk) begin
    i_even_r <= data_i_even;
    i_odd_r  <= data_i_odd;
    q_even_r <= data_q_even;
    q_odd_r  <= data_q_odd;
    oor_i_r  <= oor_i;
    oor_q_r  <= oor_q;
  end

  always_ff @(negedge adc_clk) begin
    i_even_f <= data_i_even;
    i_odd_f  <= data_i_odd;
    q_even_f <= data_q_even;
    q_odd_f  <= data_q_odd;
    oor_i_f  <= oor_i;
    oor_q_f  <= oor_q;
  end

  //////////////////////////////////////////////////
  // output word, one cycle after the rise sample
  //////////////////////////////////////////////////

  // the fall half moves back onto the rising edge here.
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      adc_data <= '0;
      adc_oor  <= '0;
      adc_sync <= 1'b0;
    end else begin
      adc_data <= {q_even_r, q_odd_r, q_even_f, q_odd_f,
                   i_even_r, i_odd_r, i_even_f, i_odd_f};
      adc_oor  <= {oor_i_f, oor_q_f, oor_i_r, oor_q_r};
      adc_sync <= sync_in;  // single register, no edge pairing.
    end
  end

  // flags feed straight into status logic downstream.
  a_oor_known: assert property (@(posedge adc_clk) disable iff (!rst_n)
    !$isunknown(adc_oor));

endmodule

// ==== logic/iadc_ctrl_timer.sv ====
`timescale 1ns/1ps
`include "iadc_defs.svh"

module iadc_ctrl_timer (
  input  logic                  adc_clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  iadc_pkg::ctrl_frame_t load_count,
  input  logic                  pulse_mode,
  output logic                  bit_tick,
  output logic                  half_phase,
  output logic                  count_done
);

  localparam int unsigned PH_W = $clog2(`IADC_CTRL_DIV);

  logic                  running;
  logic                  pulse_q;  // mode latched at start.
  logic [PH_W-1:0]       phase;
  iadc_pkg::ctrl_frame_t count;
  logic                  step;

  assign bit_tick   = running && (phase == PH_W'(`IADC_CTRL_DIV - 1));
  assign half_phase = running && (phase >= PH_W'(`IADC_CTRL_DIV / 2));
  assign step       = pulse_q ? running : bit_tick;  // pulse mode counts every cycle.
  assign count_done = step && (count == '0);

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
      pulse_q <= 1'b0;
      phase   <= '0;
      count   <= '0;
    end else if (start) begin
      // a restart also realigns the bit period.
      running <= 1'b1;
      pulse_q <= pulse_mode;
      phase   <= '0;
      count   <= load_count;
    end else if (running) begin
      phase <= bit_tick ? '0 : phase + 1'b1;
      if (count_done) begin
        running <= 1'b0;
      end else if (step) begin
        count <= count - 1'b1;
      end
    end
  end

  a_phase_range: assert property (@(posedge adc_clk) disable iff (!rst_n)
    int'(phase) < `IADC_CTRL_DIV);

endmodule

// ==== logic/iadc_ctrl_shifter.sv ====
`timescale 1ns/1ps
`include "iadc_defs.svh"

module iadc_ctrl_shifter (
  input  logic                 adc_clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic                 shift,
  input  iadc_pkg::ctrl_addr_t addr,
  input  iadc_pkg::ctrl_data_t wdata,
  output logic                 ctrl_data
);

  //////////////////////////////////////////////////
  // frame register, address on top
  //////////////////////////////////////////////////

  iadc_pkg::ctrl_frame_t frame;

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      frame <= '0;
    end else if (load) begin
      frame <= {addr, wdata};
    end else if (shift) begin
      // next bit moves up into the output position.
      frame <= {frame[`IADC_FRAME_W-2:0], 1'b0};
    end
  end

  // msb drives the pin for the whole bit period.
  assign ctrl_data = frame[`IADC_FRAME_W-1];

endmodule

// ==== logic/iadc_ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "iadc_defs.svh"

module iadc_ctrl_fsm (
  input  logic                  adc_clk,
  input  logic                  rst_n,
  input  logic                  ctrl_write,
  input  logic                  ddrb_req,
  input  logic                  bit_tick,
  input  logic                  half_phase,
  input  logic                  count_done,
  output logic                  timer_start,
  output iadc_pkg::ctrl_frame_t timer_load,
  output logic                  pulse_mode,
  output logic                  shifter_load,
  output logic                  shifter_shift,
  output logic                  ctrl_clk,
  output logic                  ctrl_strobe_n,
  output logic                  ddrb,
  output logic                  ctrl_busy
);

  iadc_pkg::ctrl_state_t state;
  iadc_pkg::ctrl_state_t state_nxt;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      iadc_pkg::ST_IDLE: begin
        if (ctrl_write) begin
          state_nxt = iadc_pkg::ST_SETUP;  // write wins a tie.
        end else if (ddrb_req) begin
          state_nxt = iadc_pkg::ST_DDRB;
        end
      end
      iadc_pkg::ST_SETUP: if (count_done) state_nxt = iadc_pkg::ST_SHIFT;
      iadc_pkg::ST_SHIFT: if (count_done) state_nxt = iadc_pkg::ST_HOLD;
      iadc_pkg::ST_HOLD:  if (count_done) state_nxt = iadc_pkg::ST_IDLE;
      iadc_pkg::ST_DDRB:  if (count_done) state_nxt = iadc_pkg::ST_IDLE;
      default:            state_nxt = iadc_pkg::ST_IDLE;
    endcase
  end

  // every state except idle runs on its own timer load.
  assign timer_start = (state_nxt != state) && (state_nxt != iadc_pkg::ST_IDLE);
  assign pulse_mode  = (state_nxt == iadc_pkg::ST_DDRB);

  always_comb begin
    case (state_nxt)
      iadc_pkg::ST_SHIFT: timer_load = iadc_pkg::ctrl_frame_t'(`IADC_FRAME_W - 1);
      iadc_pkg::ST_DDRB:  timer_load = iadc_pkg::ctrl_frame_t'(`IADC_DDRB_CYCLES - 1);
      default:            timer_load = '0;  // setup and hold last one period.
    endcase
  end

  assign shifter_load  = (state == iadc_pkg::ST_IDLE) && (state_nxt == iadc_pkg::ST_SETUP);
  assign shifter_shift = (state == iadc_pkg::ST_SHIFT) && bit_tick;

  // low in the first half of each shift period, high in the second.
  assign ctrl_clk = (state == iadc_pkg::ST_SHIFT) && half_phase;

  //////////////////////////////////////////////////
  // state and pin registers
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= iadc_pkg::ST_IDLE;
      ctrl_strobe_n <= 1'b1;
      ddrb          <= 1'b0;
      ctrl_busy     <= 1'b0;
    end else begin
      state         <= state_nxt;
      ctrl_strobe_n <= !((state_nxt == iadc_pkg::ST_SETUP) ||
                         (state_nxt == iadc_pkg::ST_SHIFT));
      ddrb          <= (state_nxt == iadc_pkg::ST_DDRB);
      ctrl_busy     <= (state_nxt != iadc_pkg::ST_IDLE);
    end
  end

  a_idle_strobe: assert property (@(posedge adc_clk) disable iff (!rst_n)
    (state == iadc_pkg::ST_IDLE) |-> ctrl_strobe_n);

  a_ddrb_excl: assert property (@(posedge adc_clk) disable iff (!rst_n)
    !(ddrb && !ctrl_strobe_n));

endmodule

// ==== logic/iadc_top.sv ====
`timescale 1ns/1ps

module iadc_top (
  input  logic                   adc_clk,
  input  logic                   rst_n,
  input  iadc_pkg::lane_t        data_i_even,
  input  iadc_pkg::lane_t        data_i_odd,
  input  iadc_pkg::lane_t        data_q_even,
  input  iadc_pkg::lane_t        data_q_odd,
  input  logic                   oor_i,
  input  logic                   oor_q,
  input  logic                   sync_in,
  input  logic                   ctrl_write,
  input  iadc_pkg::ctrl_addr_t   ctrl_addr,
  input  iadc_pkg::ctrl_data_t   ctrl_wdata,
  input  logic                   ddrb_req,
  input  logic                   mode_sel,
  output iadc_pkg::sample_word_t adc_data,
  output iadc_pkg::oor_t         adc_oor,
  output logic                   adc_sync,
  output logic                   ctrl_clk,
  output logic                   ctrl_data,
  output logic                   ctrl_strobe_n,
  output logic                   ddrb,
  output logic                   mode,
  output logic                   ctrl_busy
);

  logic                  timer_start;
  iadc_pkg::ctrl_frame_t timer_load;
  logic                  pulse_mode;
  logic                  shifter_load;
  logic                  shifter_shift;
  logic                  bit_tick;
  logic                  half_phase;
  logic                  count_done;

  assign mode = mode_sel;  // static pin, no timing.

  //////////////////////////////////////////////////
  // capture path
  //////////////////////////////////////////////////

  iadc_ddr_capture iadc_ddr_capture_inst (
    .adc_clk     (adc_clk),
    .rst_n       (rst_n),
    .data_i_even (data_i_even),
    .data_i_odd  (data_i_odd),
    .data_q_even (data_q_even),
    .data_q_odd  (data_q_odd),
    .oor_i       (oor_i),
    .oor_q       (oor_q),
    .sync_in     (sync_in),
    .adc_data    (adc_data),
    .adc_oor     (adc_oor),
    .adc_sync    (adc_sync)
  );

  //////////////////////////////////////////////////
  // control path
  //////////////////////////////////////////////////

  iadc_ctrl_fsm iadc_ctrl_fsm_inst (
    .adc_clk       (adc_clk),
    .rst_n         (rst_n),
    .ctrl_write    (ctrl_write),
    .ddrb_req      (ddrb_req),
    .bit_tick      (bit_tick),
    .half_phase    (half_phase),
    .count_done    (count_done),
    .timer_start   (timer_start),
    .timer_load    (timer_load),
    .pulse_mode    (pulse_mode),
    .shifter_load  (shifter_load),
    .shifter_shift (shifter_shift),
    .ctrl_clk      (ctrl_clk),
    .ctrl_strobe_n (ctrl_strobe_n),
    .ddrb          (ddrb),
    .ctrl_busy     (ctrl_busy)
  );

  iadc_ctrl_timer iadc_ctrl_timer_inst (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .start      (timer_start),
    .load_count (timer_load),
    .pulse_mode (pulse_mode),
    .bit_tick   (bit_tick),
    .half_phase (half_phase),
    .count_done (count_done)
  );

  iadc_ctrl_shifter iadc_ctrl_shifter_inst (
    .adc_clk   (adc_clk),
    .rst_n     (rst_n),
    .load      (shifter_load),
    .shift     (shifter_shift),
    .addr      (ctrl_addr),
    .wdata     (ctrl_wdata),
    .ctrl_data (ctrl_data)
  );

endmodule

// ==== test/iadc_checker.sv ====
`timescale 1ns/1ps
`include "iadc_defs.svh"

module iadc_checker (
  input  logic                   adc_clk,
  input  logic                   rst_n,
  input  iadc_pkg::sample_word_t adc_data,
  input  iadc_pkg::oor_t         adc_oor,
  input  logic                   adc_sync,
  input  logic                   ctrl_clk,
  input  logic                   ctrl_data,
  input  logic                   ctrl_strobe_n,
  input  logic                   ddrb,
  input  logic                   ctrl_busy,
  input  logic                   mode,
  input  logic                   mode_sel,
  output int                     errors,
  output int                     checks
);

  logic [68:0]           cap_q[$];    // {word, oor, sync} per output cycle.
  iadc_pkg::ctrl_frame_t frame_q[$];
  logic [68:0]           exp_cap;
  iadc_pkg::ctrl_frame_t exp_frame;
  iadc_pkg::ctrl_frame_t bits;        // serial bits seen so far in msb-first order.
  int                    nbits;
  int                    pulse_len;
  int                    pulses_due;
  int                    busy_len;
  int                    exp_busy;
  logic                  clk_d;
  logic                  strobe_d;
  logic                  ddrb_d;
  logic                  busy_d;

  initial begin
    errors     = 0;
    checks     = 0;
    nbits      = 0;
    pulse_len  = 0;
    pulses_due = 0;
    busy_len   = 0;
    clk_d      = 1'b0;
    strobe_d   = 1'b1;
    ddrb_d     = 1'b0;
    busy_d     = 1'b0;
  end

  task automatic report(input string msg);
    errors++;
    $display("** Error (%0t ns): %s", $time, msg);
  endtask

  task automatic push_capture(input logic [68:0] cap);
    cap_q.push_back(cap);
  endtask

  task automatic expect_frame(input iadc_pkg::ctrl_frame_t frame);
    frame_q.push_back(frame);
  endtask

  task automatic add_pulse();
    pulses_due++;
  endtask

  // anything still queued at the end never showed up on the pins.
  task automatic close_checks();
    if (cap_q.size() != 0 || frame_q.size() != 0 || pulses_due != 0) begin
      errors++;
      $display("checker: %0d capture words, %0d frames and %0d ddrb pulses never appeared",
               cap_q.size(), frame_q.size(), pulses_due);
    end
  endtask

  always @(posedge rst_n) begin
    checks++;
    if (ctrl_strobe_n !== 1'b1 || ctrl_clk !== 1'b0 || ctrl_data !== 1'b0 ||
        ddrb !== 1'b0 || ctrl_busy !== 1'b0 || adc_sync !== 1'b0 ||
        adc_data !== '0 || adc_oor !== '0) begin
      report("outputs are not at their reset values");
    end
  end

  //////////////////////////////////////////////////
  // mid-cycle sampling of settled outputs
  //////////////////////////////////////////////////

  always @(negedge adc_clk) begin
    if (mode !== mode_sel) report("mode does not follow mode_sel");
    if (rst_n) begin
      if (cap_q.size() > 0) begin
        exp_cap = cap_q.pop_front();
        checks++;
        if ({adc_data, adc_oor, adc_sync} !== exp_cap) begin
          report($sformatf("capture got %h/%h/%b, expected %h/%h/%b", adc_data, adc_oor,
                           adc_sync, exp_cap[68:5], exp_cap[4:1], exp_cap[0]));
        end
      end
      if (!ctrl_strobe_n && ctrl_clk && !clk_d) begin  // adc samples here.
        bits = {bits[`IADC_FRAME_W-2:0], ctrl_data};
        nbits++;
      end
      if (ctrl_strobe_n && !strobe_d) begin
        checks++;
        if (frame_q.size() == 0) begin
          report("control frame sent without an accepted write");
        end else begin
          exp_frame = frame_q.pop_front();
          if (nbits != `IADC_FRAME_W || bits !== exp_frame) begin
            report($sformatf("frame got %0d bits %h, expected %h", nbits, bits, exp_frame));
          end
        end
        nbits = 0;
      end
      if (ddrb) begin
        pulse_len++;
        if (!ctrl_strobe_n) report("ctrl_strobe_n low during ddrb");
      end else if (ddrb_d) begin
        checks++;
        if (pulses_due == 0) report("ddrb pulse without an accepted request");
        else pulses_due--;
        if (pulse_len != `IADC_DDRB_CYCLES) begin
          report($sformatf("ddrb high for %0d cycles, expected %0d", pulse_len,
                           `IADC_DDRB_CYCLES));
        end
        pulse_len = 0;
      end
      // setup, one period per frame bit, then hold.
      if (ctrl_busy) begin
        busy_len++;
      end else if (busy_d) begin
        checks++;
        exp_busy = ddrb_d ? `IADC_DDRB_CYCLES : (`IADC_FRAME_W + 2) * `IADC_CTRL_DIV;
        if (busy_len != exp_busy) begin
          report($sformatf("ctrl_busy high for %0d cycles, expected %0d", busy_len,
                           exp_busy));
        end
        busy_len = 0;
      end
    end
    clk_d    = ctrl_clk;
    strobe_d = ctrl_strobe_n;
    ddrb_d   = ddrb;
    busy_d   = ctrl_busy;
  end

endmodule

// ==== test/tb_iadc_top.sv ====
`timescale 1ns/1ps

module tb_iadc_top;

  localparam logic [1:0] K_BURST = 2'd0;
  localparam logic [1:0] K_WRITE = 2'd1;
  localparam logic [1:0] K_DDRB  = 2'd2;
  localparam int         N_STEPS = 8;

  // a is cycles or address, b is seed mix or data, tie adds ddrb_req to a write.
  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic        tie;
  } step_t;

  step_t       steps [N_STEPS];
  logic [31:0] rng;
  logic        adc_clk, rst_n, oor_i, oor_q, sync_in, mode_sel;
  logic        ctrl_write, ddrb_req;
  logic        adc_sync, ctrl_clk, ctrl_data, ctrl_strobe_n, ddrb, mode, ctrl_busy;
  int          errors, checks;

  iadc_pkg::lane_t        data_i_even, data_i_odd, data_q_even, data_q_odd;
  iadc_pkg::ctrl_addr_t   ctrl_addr;
  iadc_pkg::ctrl_data_t   ctrl_wdata;
  iadc_pkg::sample_word_t adc_data;
  iadc_pkg::oor_t         adc_oor;

  iadc_top iadc_top_inst (.*);
  iadc_checker iadc_checker_inst (.*);

  always #5 adc_clk = ~adc_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic next_cycle();
    @(posedge adc_clk);
    #1;
  endtask

  task automatic wait_idle();
    while (ctrl_busy) next_cycle();
  endtask

  // both requests land while busy and must be dropped.
  task automatic poke_while_busy();
    next_cycle();
    next_cycle();
    ctrl_write = 1'b1;
    ddrb_req   = 1'b1;
    ctrl_addr  = ~ctrl_addr;
    ctrl_wdata = ~ctrl_wdata;
    next_cycle();
    ctrl_write = 1'b0;
    ddrb_req   = 1'b0;
    wait_idle();
  endtask

  task automatic send_write(input iadc_pkg::ctrl_addr_t addr, input iadc_pkg::ctrl_data_t data,
                            input logic tie);
    wait_idle();
    ctrl_addr  = addr;
    ctrl_wdata = data;
    ctrl_write = 1'b1;
    ddrb_req   = tie;  // write wins a tie.
    iadc_checker_inst.expect_frame({addr, data});
    next_cycle();
    ctrl_write = 1'b0;
    ddrb_req   = 1'b0;
    poke_while_busy();
  endtask

  task automatic pulse_ddrb();
    wait_idle();
    ddrb_req = 1'b1;
    iadc_checker_inst.add_pulse();
    next_cycle();
    ddrb_req = 1'b0;
    poke_while_busy();
  endtask

  //////////////////////////////////////////////////
  // ddr burst, rise lanes before posedge, fall lanes before negedge
  //////////////////////////////////////////////////

  task automatic run_burst(input logic [31:0] cycles, input logic [31:0] seed_mix);
    logic [31:0] r_rise, r_fall, r_flag;
    logic [68:0] exp_cap;
    rng = rng ^ seed_mix;
    for (int unsigned n = 0; n <= cycles; n++) begin
      @(negedge adc_clk);
      #1;
      if (n < cycles) begin
        rng    = lcg_next(rng);
        r_rise = rng;
        rng    = lcg_next(rng);
        r_flag = rng;
        {data_i_even, data_i_odd, data_q_even, data_q_odd} = r_rise;
        {oor_i, oor_q} = r_flag[31:30];
      end
      next_cycle();
      if (n > 0) iadc_checker_inst.push_capture(exp_cap);  // pair from last cycle is out.
      if (n < cycles) begin
        rng    = lcg_next(rng);
        r_fall = rng;
        {data_i_even, data_i_odd, data_q_even, data_q_odd} = r_fall;
        {oor_i, oor_q} = r_flag[29:28];
        sync_in  = r_flag[27];
        mode_sel = r_flag[26];
        // q rise, q fall, i rise, i fall. flags i fall, q fall, i rise, q rise.
        exp_cap = {r_rise[15:0], r_fall[15:0], r_rise[31:16], r_fall[31:16],
                   r_flag[29], r_flag[28], r_flag[31], r_flag[30], r_flag[27]};
      end
    end
  endtask

  initial begin
    adc_clk     = 1'b0;
    rst_n       = 1'b0;
    {data_i_even, data_i_odd, data_q_even, data_q_odd} = '0;
    {oor_i, oor_q, sync_in, mode_sel} = '0;
    {ctrl_write, ddrb_req} = '0;
    ctrl_addr   = '0;
    ctrl_wdata  = '0;
    rng         = 32'h87d6;
    steps[0] = '{K_BURST, 32'd40, 32'h0000_0000, 1'b0};
    steps[1] = '{K_WRITE, 32'd5, 32'h0000_a5c3, 1'b0};
    steps[2] = '{K_BURST, 32'd25, 32'h0000_1357, 1'b0};
    steps[3] = '{K_DDRB, 32'd0, 32'd0, 1'b0};
    steps[4] = '{K_WRITE, 32'd2, 32'h0000_0f81, 1'b1};
    steps[5] = '{K_BURST, 32'd30, 32'h0000_2468, 1'b0};
    steps[6] = '{K_DDRB, 32'd0, 32'd0, 1'b0};
    steps[7] = '{K_WRITE, 32'd7, 32'h0000_8001, 1'b0};
    repeat (8) @(posedge adc_clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < N_STEPS; i++) begin
      case (steps[i].kind)
        K_BURST: run_burst(steps[i].a, steps[i].b);
        K_WRITE: send_write(steps[i].a[2:0], steps[i].b[15:0], steps[i].tie);
        default: pulse_ddrb();
      endcase
    end
    repeat (4) next_cycle();
    iadc_checker_inst.close_checks();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // budget of 100 cycles per burst cycle and per request.
  initial begin
    int unsigned limit;
    #1;
    limit = 0;
    for (int i = 0; i < N_STEPS; i++) begin
      limit += (steps[i].kind == K_BURST) ? steps[i].a : 32'd1;
    end
    limit = limit * 100;
    repeat (limit) @(posedge adc_clk);
    $display("watchdog: run timed out after %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+logic
logic/iadc_pkg.sv
logic/iadc_ddr_capture.sv
logic/iadc_ctrl_timer.sv
logic/iadc_ctrl_shifter.sv
logic/iadc_ctrl_fsm.sv
logic/iadc_top.sv
test/iadc_checker.sv
test/tb_iadc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, and judge the run from its log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_iadc_top -f sim.f \
  && ./obj_dir/Vtb_iadc_top > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
